// ==== common/rv_cfg.svh ====
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// data and address width
`define RV_XLEN 32
`define RV_NREGS 32
`define RV_RESET_PC 32'h8000_0000

`endif

// ==== common/rv_pkg.sv ====
`default_nettype none

package rv_pkg;

    // one struct per RISC-V format, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } inst_b_t;

    typedef struct packed {
        logic [19:0] imm_31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } inst_u_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } inst_j_t;

    typedef union packed {
        inst_r_t r;
        inst_i_t i;
        inst_s_t s;
        inst_b_t b;
        inst_u_t u;
        inst_j_t j;
    } inst_u;

    typedef enum logic [2:0] {
        FMT_R,
        FMT_I,
        FMT_S,
        FMT_B,
        FMT_U,
        FMT_J,
        FMT_N  // unknown opcode, retires as nop
    } inst_fmt_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND
    } alu_op_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;

endpackage

`default_nettype wire

// ==== common/core_ifs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

// decoded fields of the instruction register
interface dec_if
    import rv_pkg::*;
();
    logic [6:0]         opcode;
    logic [2:0]         funct3;
    logic [6:0]         funct7;
    logic [4:0]         rs1;
    logic [4:0]         rs2;
    logic [4:0]         rd;
    logic [`RV_XLEN-1:0] imm;
    inst_fmt_t          fmt;

    modport dec (output opcode, funct3, funct7, rs1, rs2, rd, imm, fmt);
    modport exu (input opcode, funct3, funct7, rs1, rs2, rd, imm, fmt);
    modport seq (input opcode, funct3, funct7, rs1, rs2, rd, imm, fmt);
endinterface

interface exu_if ();
    logic [`RV_XLEN-1:0] result;     // alu value, doubles as mem address
    logic [`RV_XLEN-1:0] wb_val;
    logic                wb_en;
    logic [`RV_XLEN-1:0] next_pc;
    logic [`RV_XLEN-1:0] store_val;

    modport exu (output result, wb_val, wb_en, next_pc, store_val);
    modport seq (input result, wb_val, wb_en, next_pc, store_val);
endinterface

`default_nettype wire

// ==== exec/alu.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module alu
    import rv_pkg::*;
(
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  alu_op_t             op,
    output logic [`RV_XLEN-1:0] y
);
    logic [4:0] shamt;

    assign shamt = b[4:0];  // only low five bits shift

    always_comb begin
        unique case (op)
            ALU_ADD:  y = a + b;
            ALU_SUB:  y = a - b;
            ALU_SLL:  y = a << shamt;
            ALU_SLT:  y = {{(`RV_XLEN-1){1'b0}}, $signed(a) < $signed(b)};
            ALU_SLTU: y = {{(`RV_XLEN-1){1'b0}}, a < b};
            ALU_XOR:  y = a ^ b;
            ALU_SRL:  y = a >> shamt;
            ALU_SRA:  y = $unsigned($signed(a) >>> shamt);
            ALU_OR:   y = a | b;
            ALU_AND:  y = a & b;
            default:  y = a + b;
        endcase
    end

endmodule

`default_nettype wire

// ==== exec/exec_unit.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module exec_unit
    import rv_pkg::*;
(
    dec_if.exu                  dec,
    input  logic [`RV_XLEN-1:0] src1,
    input  logic [`RV_XLEN-1:0] src2,
    input  logic [`RV_XLEN-1:0] pc,
    exu_if.exu                  exu
);
    logic [`RV_XLEN-1:0] alu_a;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] snpc;
    alu_op_t             alu_op;
    logic                taken;
    logic                is_jal;
    logic                is_jalr;

    alu u_alu (
        .a  (alu_a),
        .b  (alu_b),
        .op (alu_op),
        .y  (alu_y)
    );

    assign snpc    = pc + 32'd4;
    assign is_jal  = (dec.opcode == OPC_JAL);
    assign is_jalr = (dec.opcode == OPC_JALR);

    always_comb begin
        unique case (dec.fmt)
            FMT_R:        {alu_a, alu_b} = {src1, src2};
            FMT_I, FMT_S: {alu_a, alu_b} = {src1, dec.imm};
            FMT_B, FMT_J: {alu_a, alu_b} = {pc, dec.imm};  // target adder
            FMT_U:        {alu_a, alu_b} = {(dec.opcode == OPC_LUI) ? '0 : pc, dec.imm};
            default:      {alu_a, alu_b} = {src1, src2};
        endcase
    end

    always_comb begin
        alu_op = ALU_ADD;
        if (dec.opcode == OPC_OP || dec.opcode == OPC_OP_IMM) begin
            unique case (dec.funct3)
                3'b000: alu_op = (dec.fmt == FMT_R && dec.funct7[5]) ? ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = dec.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    // branch condition, only meaningful for the B format
    always_comb begin
        unique case (dec.funct3)
            3'b000:  taken = (src1 == src2);
            3'b001:  taken = (src1 != src2);
            3'b100:  taken = ($signed(src1) < $signed(src2));
            3'b101:  taken = ($signed(src1) >= $signed(src2));
            3'b110:  taken = (src1 < src2);
            3'b111:  taken = (src1 >= src2);
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        if (is_jalr) begin
            exu.next_pc = {alu_y[`RV_XLEN-1:1], 1'b0};
        end else if (is_jal || (dec.fmt == FMT_B && taken)) begin
            exu.next_pc = alu_y;
        end else begin
            exu.next_pc = snpc;
        end
    end

    assign exu.result    = alu_y;
    assign exu.wb_val    = (is_jal || is_jalr) ? snpc : alu_y;  // link value
    assign exu.store_val = src2;
    assign exu.wb_en     = (dec.opcode == OPC_OP) || (dec.opcode == OPC_OP_IMM)
                        || (dec.opcode == OPC_LUI) || (dec.opcode == OPC_AUIPC)
                        || is_jal || is_jalr;

endmodule

`default_nettype wire

// ==== rtl/inst_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
    import rv_pkg::*;
(
    input  inst_u ir,
    dec_if.dec    dec
);
    inst_fmt_t fmt;

    assign dec.opcode = ir.r.opcode;
    assign dec.funct3 = ir.r.funct3;
    assign dec.funct7 = ir.r.funct7;
    assign dec.rs1    = ir.r.rs1;
    assign dec.rs2    = ir.r.rs2;
    assign dec.rd     = ir.r.rd;
    assign dec.fmt    = fmt;

    always_comb begin
        unique case (ir.r.opcode)
            OPC_OP:                       fmt = FMT_R;
            OPC_OP_IMM, OPC_LOAD, OPC_JALR: fmt = FMT_I;
            OPC_STORE:                    fmt = FMT_S;
            OPC_BRANCH:                   fmt = FMT_B;
            OPC_LUI, OPC_AUIPC:           fmt = FMT_U;
            OPC_JAL:                      fmt = FMT_J;
            default:                      fmt = FMT_N;
        endcase
    end

    // immediate through the view of its format
    always_comb begin
        unique case (fmt)
            FMT_I: dec.imm = {{20{ir.i.imm[11]}}, ir.i.imm};
            FMT_S: dec.imm = {{20{ir.s.imm_hi[6]}}, ir.s.imm_hi, ir.s.imm_lo};
            FMT_B: dec.imm = {{20{ir.b.imm_12}}, ir.b.imm_11, ir.b.imm_10_5,
                              ir.b.imm_4_1, 1'b0};
            FMT_U: dec.imm = {ir.u.imm_31_12, 12'b0};
            FMT_J: dec.imm = {{12{ir.j.imm_20}}, ir.j.imm_19_12, ir.j.imm_11,
                              ir.j.imm_10_1, 1'b0};
            default: dec.imm = '0;  // R and N carry no immediate
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/reg_file.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module reg_file (
    input  logic                clk,
    input  logic [4:0]          raddr1,
    input  logic [4:0]          raddr2,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2,
    input  logic                we,
    input  logic [4:0]          waddr,
    input  logic [`RV_XLEN-1:0] wdata
);
    logic [`RV_XLEN-1:0] regs [`RV_NREGS];

    always_ff @(posedge clk) begin
        if (we && waddr != 5'd0) begin  // x0 never written
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== rtl/core_seq.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module core_seq
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    output logic [`RV_XLEN-1:0]   wb_adr,
    output logic [`RV_XLEN-1:0]   wb_dat_w,
    input  logic [`RV_XLEN-1:0]   wb_dat_r,
    output logic [`RV_XLEN/8-1:0] wb_sel,
    output logic                  wb_we,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    input  logic                  wb_ack,
    dec_if.seq                    dec,
    exu_if.seq                    exu,
    output logic [`RV_XLEN-1:0]   pc,
    output inst_u                 ir,
    output logic                  rf_we,
    output logic [4:0]            rf_waddr,
    output logic [`RV_XLEN-1:0]   rf_wdata
);
    localparam logic [1:0] S_FETCH = 2'd0;
    localparam logic [1:0] S_EXEC  = 2'd1;
    localparam logic [1:0] S_MEM   = 2'd2;

    logic [1:0]            state;
    logic                  is_load;
    logic                  is_mem;
    logic                  bus_done;
    logic [`RV_XLEN/8-1:0] lane_sel;
    logic [`RV_XLEN-1:0]   st_data;
    logic [7:0]            ld_byte;
    logic [15:0]           ld_half;
    logic [`RV_XLEN-1:0]   ld_val;

    assign is_load  = (dec.opcode == OPC_LOAD);
    assign is_mem   = is_load || (dec.opcode == OPC_STORE);
    assign bus_done = wb_cyc && wb_ack;

    // lanes and replicated store data, from size and address
    always_comb begin
        unique case (dec.funct3[1:0])
            2'b00: begin
                lane_sel = 4'b0001 << exu.result[1:0];
                st_data  = {4{exu.store_val[7:0]}};
            end
            2'b01: begin
                lane_sel = exu.result[1] ? 4'b1100 : 4'b0011;
                st_data  = {2{exu.store_val[15:0]}};
            end
            default: begin
                lane_sel = 4'b1111;
                st_data  = exu.store_val;
            end
        endcase
    end

    // pick the addressed lane of the read data
    always_comb begin
        ld_byte = wb_dat_r[{wb_adr[1:0], 3'b000} +: 8];
        ld_half = wb_adr[1] ? wb_dat_r[31:16] : wb_dat_r[15:0];
        unique case (dec.funct3)
            3'b000:  ld_val = {{(`RV_XLEN-8){ld_byte[7]}}, ld_byte};    // lb
            3'b001:  ld_val = {{(`RV_XLEN-16){ld_half[15]}}, ld_half};  // lh
            3'b100:  ld_val = {{(`RV_XLEN-8){1'b0}}, ld_byte};          // lbu
            3'b101:  ld_val = {{(`RV_XLEN-16){1'b0}}, ld_half};         // lhu
            default: ld_val = wb_dat_r;
        endcase
    end

    assign rf_waddr = dec.rd;
    assign rf_we    = (state == S_EXEC) ? exu.wb_en : (state == S_MEM) && bus_done && is_load;
    assign rf_wdata = (state == S_MEM) ? ld_val : exu.wb_val;

    always_ff @(posedge clk) begin
        if (reset) begin
            state  <= S_FETCH;
            pc     <= `RV_RESET_PC;
            wb_cyc <= 1'b0;
            wb_stb <= 1'b0;
            wb_we  <= 1'b0;
        end else begin
            unique case (state)
                S_FETCH: begin
                    if (!wb_cyc) begin  // open the fetch read
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= 1'b0;
                    end else if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        state  <= S_EXEC;
                    end
                end
                S_EXEC: begin
                    if (is_mem) begin
                        wb_cyc <= 1'b1;
                        wb_stb <= 1'b1;
                        wb_we  <= !is_load;
                        state  <= S_MEM;
                    end else begin
                        pc    <= exu.next_pc;
                        state <= S_FETCH;
                    end
                end
                S_MEM: begin
                    if (wb_ack) begin
                        wb_cyc <= 1'b0;
                        wb_stb <= 1'b0;
                        wb_we  <= 1'b0;
                        pc     <= exu.next_pc;
                        state  <= S_FETCH;
                    end
                end
                default: state <= S_FETCH;
            endcase
        end
    end

    // bus payload and instruction word
    always_ff @(posedge clk) begin
        if (state == S_FETCH && !wb_cyc) begin
            wb_adr <= pc;
            wb_sel <= 4'b1111;
        end
        if (state == S_FETCH && bus_done) begin
            ir <= wb_dat_r;
        end
        if (state == S_EXEC && is_mem) begin
            wb_adr   <= exu.result;
            wb_sel   <= lane_sel;
            wb_dat_w <= st_data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module rv_core_top
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    output logic [`RV_XLEN-1:0]   wb_adr,
    output logic [`RV_XLEN-1:0]   wb_dat_w,
    input  logic [`RV_XLEN-1:0]   wb_dat_r,
    output logic [`RV_XLEN/8-1:0] wb_sel,
    output logic                  wb_we,
    output logic                  wb_cyc,
    output logic                  wb_stb,
    input  logic                  wb_ack
);
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] src1;
    logic [`RV_XLEN-1:0] src2;
    logic [`RV_XLEN-1:0] rf_wdata;
    logic [4:0]          rf_waddr;
    logic                rf_we;
    inst_u               ir;

    dec_if dec_i ();
    exu_if exu_i ();

    core_seq u_seq (
        .clk      (clk),
        .reset    (reset),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_ack   (wb_ack),
        .dec      (dec_i.seq),
        .exu      (exu_i.seq),
        .pc       (pc),
        .ir       (ir),
        .rf_we    (rf_we),
        .rf_waddr (rf_waddr),
        .rf_wdata (rf_wdata)
    );

    inst_decoder u_dec (
        .ir  (ir),
        .dec (dec_i.dec)
    );

    reg_file u_rf (
        .clk    (clk),
        .raddr1 (dec_i.rs1),
        .raddr2 (dec_i.rs2),
        .rdata1 (src1),
        .rdata2 (src2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    exec_unit u_exu (
        .dec  (dec_i.exu),
        .src1 (src1),
        .src2 (src2),
        .pc   (pc),
        .exu  (exu_i.exu)
    );

endmodule

`default_nettype wire

// ==== sim/bus_checker.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module bus_checker (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`RV_XLEN-1:0]   wb_adr,
    input  logic [`RV_XLEN-1:0]   wb_dat_w,
    input  logic [`RV_XLEN/8-1:0] wb_sel,
    input  logic                  wb_we,
    input  logic                  wb_cyc,
    input  logic                  wb_stb,
    input  logic                  wb_ack,
    output int                    writes_seen,
    output int                    mismatches,
    output int                    other_errors
);
    localparam logic [`RV_XLEN-1:0] WINDOW_MASK = 32'hffff_fc00;  // 1 KiB memory model

    logic [`RV_XLEN-1:0]   exp_adr_q [$];
    logic [`RV_XLEN-1:0]   exp_dat_q [$];
    logic [`RV_XLEN/8-1:0] exp_sel_q [$];
    logic                  first_seen;

    task automatic add_expected(input logic [`RV_XLEN-1:0] adr, input logic [`RV_XLEN-1:0] dat,
                                input logic [`RV_XLEN/8-1:0] sel);
        exp_adr_q.push_back(adr);
        exp_dat_q.push_back(dat);
        exp_sel_q.push_back(sel);
    endtask

    task automatic report_missing();
        foreach (exp_adr_q[i]) begin
            $display("Missing bus write: address %h data %h sel %h",
                     exp_adr_q[i], exp_dat_q[i], exp_sel_q[i]);
        end
    endtask

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0d ns: %s expected %h got %h", $time, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic check_write();
        if (exp_adr_q.size() == 0) begin
            $display("Unexpected extra bus write at %0d ns to address %h with data %h",
                     $time, wb_adr, wb_dat_w);
            other_errors++;
        end else begin
            compare_field("wb_adr", wb_adr, exp_adr_q.pop_front());
            compare_field("wb_dat_w", wb_dat_w, exp_dat_q.pop_front());
            compare_field("wb_sel", {28'b0, wb_sel}, {28'b0, exp_sel_q.pop_front()});
        end
        writes_seen++;
    endtask

    // ack is high for one whole cycle, so the falling edge sees a settled bus
    always @(negedge clk) begin
        if (reset) begin
            writes_seen  = 0;
            mismatches   = 0;
            other_errors = 0;
            first_seen   = 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (!first_seen) begin  // first request must be the reset fetch
                first_seen = 1'b1;
                compare_field("wb_adr", wb_adr, `RV_RESET_PC);
                compare_field("wb_we", {31'b0, wb_we}, 32'd0);
            end
            if (wb_ack) begin
                if ((wb_adr & WINDOW_MASK) != `RV_RESET_PC) begin
                    $display("Bus access outside the memory window at %0d ns, address %h",
                             $time, wb_adr);
                    other_errors++;
                end
                if (wb_we) begin
                    check_write();
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "rv_cfg.svh"

module tb_rv_core;
    localparam int    MEM_WORDS     = 256;
    localparam int    WRITE_TIMEOUT = 5000;  // cycles
    localparam int    DRAIN_CYCLES  = 32;
    localparam string STIM_FILE     = "sim/rv_core_stim.txt";
    localparam byte   REC_PRELOAD   = "P";
    localparam byte   REC_WRITE     = "W";

    logic                  clk;
    logic                  reset;
    logic [`RV_XLEN-1:0]   wb_adr;
    logic [`RV_XLEN-1:0]   wb_dat_w;
    logic [`RV_XLEN-1:0]   wb_dat_r;
    logic [`RV_XLEN/8-1:0] wb_sel;
    logic                  wb_we;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_ack;
    logic [`RV_XLEN-1:0]   mem [MEM_WORDS];
    integer                seed;
    int                    exp_count;
    int                    timeouts;
    int                    writes_seen;
    int                    mismatches;
    int                    other_errors;

    rv_core_top rv_core_top_inst (
        .clk      (clk),
        .reset    (reset),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_sel   (wb_sel),
        .wb_we    (wb_we),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_ack   (wb_ack)
    );

    bus_checker bus_checker_inst (
        .clk          (clk),
        .reset        (reset),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_sel       (wb_sel),
        .wb_we        (wb_we),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_ack       (wb_ack),
        .writes_seen  (writes_seen),
        .mismatches   (mismatches),
        .other_errors (other_errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic load_stim(output bit ok);
        int                  fd;
        int                  n;
        int                  bad;
        string               line;
        logic [`RV_XLEN-1:0] adr;
        logic [`RV_XLEN-1:0] dat;
        logic [`RV_XLEN-1:0] sel;
        ok = 1'b0;
        bad = 0;
        exp_count = 0;
        foreach (mem[i]) begin
            mem[i] = '0;
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line[0] == REC_PRELOAD) begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h", adr, dat);
                if (n != 2) bad++;
                mem[adr[9:2]] = dat;
            end else if (n > 1 && line[0] == REC_WRITE) begin
                n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h", adr, dat, sel);
                if (n != 3) bad++;
                bus_checker_inst.add_expected(adr, dat, sel[3:0]);
                exp_count++;
            end
        end
        $fclose(fd);
        ok = (bad == 0) && (exp_count > 0);
    endtask

    task automatic serve_request();
        logic [7:0] idx;
        int         b;
        idx = wb_adr[9:2];
        if (wb_we) begin
            for (b = 0; b < 4; b++) begin
                if (wb_sel[b]) mem[idx][8*b +: 8] = wb_dat_w[8*b +: 8];
            end
        end else begin
            wb_dat_r = mem[idx];
        end
    endtask

    // slave with 0 to 3 wait cycles per request
    initial begin : memory_model
        int wait_cnt;
        bit busy;
        wb_ack = 1'b0;
        wb_dat_r = '0;
        seed = 32'h6e06_6538;
        busy = 1'b0;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            if (reset || wb_ack) begin  // ack was sampled on this edge
                wb_ack = 1'b0;
                busy = 1'b0;
            end else if (!busy && wb_cyc && wb_stb) begin
                busy = 1'b1;
                wait_cnt = $random(seed) & 3;
            end
            if (busy) begin
                if (wait_cnt == 0) begin
                    serve_request();
                    wb_ack = 1'b1;
                end else begin
                    wait_cnt--;
                end
            end
        end
    end

    initial begin : main_flow
        int cycles;
        bit stim_ok;
        reset = 1'b1;
        timeouts = 0;
        load_stim(stim_ok);
        if (!stim_ok) begin
            $display("Could not read a valid stimulus from %s", STIM_FILE);
            $display("Simulation FAILED");
            $finish;
        end else begin
            repeat (8) @(posedge clk);
            #1 reset = 1'b0;
            cycles = 0;
            while (writes_seen < exp_count && cycles < WRITE_TIMEOUT) begin
                @(posedge clk);
                cycles++;
            end
            if (writes_seen < exp_count) begin
                $display("Timeout after %0d cycles, only %0d of %0d bus writes seen",
                         cycles, writes_seen, exp_count);
                bus_checker_inst.report_missing();
                timeouts++;
            end else begin
                repeat (DRAIN_CYCLES) @(posedge clk);  // catch stray writes in the end loop
            end
            $display("Checks done: %0d of %0d writes, %0d mismatches, %0d other errors, %0d timeouts",
                     writes_seen, exp_count, mismatches, other_errors, timeouts);
            if (mismatches == 0 && other_errors == 0 && timeouts == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rv_core.f ====
+incdir+common
common/rv_pkg.sv
common/core_ifs.sv
exec/alu.sv
exec/exec_unit.sv
rtl/inst_decoder.sv
rtl/reg_file.sv
rtl/core_seq.sv
rtl/rv_core_top.sv
sim/bus_checker.sv
sim/tb_rv_core.sv

// ==== run_sim.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_rv_core -f rv_core.f \
    --Mdir obj_dir -o tb_rv_core

status=0
./obj_dir/tb_rv_core > run_sim.log 2>&1 || status=$?
cat run_sim.log

if grep -q "Simulation FAILED" run_sim.log || [ "$status" -ne 0 ]; then
    exit 1
fi
exit 0

// ==== sim/rv_core_stim.txt ====
# P <address> <word>          preload one memory word (hex)
# W <address> <data> <sel>    expected bus write, in order (hex)
P 80000000 80000537  lui   x10, 0x80000
P 80000004 30050513  addi  x10, x10, 0x300
P 80000008 ff900093  addi  x1, x0, -7
P 8000000c 4010d113  srai  x2, x1, 1
P 80000010 0010d193  srli  x3, x1, 1
P 80000014 00252023  sw    x2, 0(x10)
P 80000018 00352223  sw    x3, 4(x10)
P 8000001c 00500213  addi  x4, x0, 5
P 80000020 0040a2b3  slt   x5, x1, x4
P 80000024 0040b333  sltu  x6, x1, x4
P 80000028 405303b3  sub   x7, x6, x5
P 8000002c 0f03c413  xori  x8, x7, 0x0f0
P 80000030 3cc47413  andi  x8, x8, 0x3cc
P 80000034 00446433  or    x8, x8, x4
P 80000038 00441433  sll   x8, x8, x4
P 8000003c 00740433  add   x8, x8, x7
P 80000040 00852423  sw    x8, 8(x10)
P 80000044 12345497  auipc x9, 0x12345
P 80000048 00952623  sw    x9, 12(x10)
P 8000004c 05500593  addi  x11, x0, 0x55
P 80000050 00408463  beq   x1, x4, +8    not taken
P 80000054 00420463  beq   x4, x4, +8    taken
P 80000058 10058593  addi  x11, x11, 0x100  must be skipped
P 8000005c 00421463  bne   x4, x4, +8    not taken
P 80000060 00409463  bne   x1, x4, +8    taken
P 80000064 10058593  addi  x11, x11, 0x100
P 80000068 00124463  blt   x4, x1, +8    not taken
P 8000006c 0040c463  blt   x1, x4, +8    taken
P 80000070 10058593  addi  x11, x11, 0x100
P 80000074 0040d463  bge   x1, x4, +8    not taken
P 80000078 00125463  bge   x4, x1, +8    taken
P 8000007c 10058593  addi  x11, x11, 0x100
P 80000080 0040e463  bltu  x1, x4, +8    not taken
P 80000084 00126463  bltu  x4, x1, +8    taken
P 80000088 10058593  addi  x11, x11, 0x100
P 8000008c 00127463  bgeu  x4, x1, +8    not taken
P 80000090 0040f463  bgeu  x1, x4, +8    taken
P 80000094 10058593  addi  x11, x11, 0x100
P 80000098 00b52823  sw    x11, 16(x10)
P 8000009c 0080066f  jal   x12, +8
P 800000a0 00000613  addi  x12, x0, 0    must be skipped
P 800000a4 00c52a23  sw    x12, 20(x10)
P 800000a8 011606e7  jalr  x13, 17(x12)  target bit 0 cleared
P 800000ac 00000693  addi  x13, x0, 0    must be skipped
P 800000b0 00d52c23  sw    x13, 24(x10)
P 800000b4 07b00013  addi  x0, x0, 123
P 800000b8 00052e23  sw    x0, 28(x10)
P 800000bc a1b2c737  lui   x14, 0xa1b2c
P 800000c0 3d470713  addi  x14, x14, 0x3d4
P 800000c4 02e50023  sb    x14, 32(x10)
P 800000c8 02e500a3  sb    x14, 33(x10)
P 800000cc 02e50123  sb    x14, 34(x10)
P 800000d0 02e501a3  sb    x14, 35(x10)
P 800000d4 02e51223  sh    x14, 36(x10)
P 800000d8 02e51323  sh    x14, 38(x10)
P 800000dc 03150783  lb    x15, 49(x10)
P 800000e0 03354803  lbu   x16, 51(x10)
P 800000e4 03251883  lh    x17, 50(x10)
P 800000e8 03055903  lhu   x18, 48(x10)
P 800000ec 04f52023  sw    x15, 64(x10)
P 800000f0 05052223  sw    x16, 68(x10)
P 800000f4 05152423  sw    x17, 72(x10)
P 800000f8 05252623  sw    x18, 76(x10)
P 800000fc 7e500993  addi  x19, x0, 0x7e5
P 80000100 05352823  sw    x19, 80(x10)  end marker
P 80000104 0000006f  jal   x0, 0
P 80000330 e1c293a4  load data, negative bytes and halfwords
W 80000300 fffffffc f  srai of -7
W 80000304 7ffffffc f  srli of -7
W 80000308 0000619f f  slt/sltu/sub/xori/andi/or/sll/add chain
W 8000030c 92345044 f  auipc
W 80000310 00000055 f  all branches correct
W 80000314 800000a0 f  jal link
W 80000318 800000ac f  jalr link
W 8000031c 00000000 f  x0 after write
W 80000320 d4d4d4d4 1
W 80000321 d4d4d4d4 2
W 80000322 d4d4d4d4 4
W 80000323 d4d4d4d4 8
W 80000324 c3d4c3d4 3
W 80000326 c3d4c3d4 c
W 80000340 ffffff93 f  lb
W 80000344 000000e1 f  lbu
W 80000348 ffffe1c2 f  lh
W 8000034c 000093a4 f  lhu
W 80000350 000007e5 f  end marker
